// ==== Makefile ====
TOP = fix_session_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
verilog/fix_session_pkg.sv
verilog/session_config.sv
verilog/session_window.sv
verilog/heartbeat_timer.sv
verilog/session_msg_arbiter.sv
verilog/fix_session_top.sv
verification/fix_session_asserts.sv
verification/fix_session_tb.sv

// ==== verification/fix_session_asserts.sv ====
//==========================================================================
// Handshake and request checks for the session message arbiter.
// Bound into every session_msg_arbiter instance of the design.
//==========================================================================

module fix_session_asserts (
  input logic                       clk,
  input logic                       reset_i,
  input logic                       logon_req_i,
  input logic                       logout_req_i,
  input logic                       msg_ready_i,
  input logic                       msg_valid_o,
  input fix_session_pkg::msg_type_t msg_type_o
);

  // A stalled message stays offered
  property p_valid_held;
    @(posedge clk) disable iff (reset_i)
      (msg_valid_o && !msg_ready_i) |=> msg_valid_o;
  endproperty

  property p_type_held;
    @(posedge clk) disable iff (reset_i)
      (msg_valid_o && !msg_ready_i) |=> $stable(msg_type_o);
  endproperty

  // Window FSM waits on at most one of logon and logout
  property p_single_session_req;
    @(posedge clk) disable iff (reset_i)
      !(logon_req_i && logout_req_i);
  endproperty

  a_valid_held: assert property (p_valid_held)
    else $error("msg_valid_o dropped while msg_ready_i was low");

  a_type_held: assert property (p_type_held)
    else $error("msg_type_o changed while msg_ready_i was low");

  a_single_session_req: assert property (p_single_session_req)
    else $error("logon and logout requested together");

endmodule

bind session_msg_arbiter fix_session_asserts u_asserts (
  .clk          (clk),
  .reset_i      (reset_i),
  .logon_req_i  (logon_req_i),
  .logout_req_i (logout_req_i),
  .msg_ready_i  (msg_ready_i),
  .msg_valid_o  (msg_valid_o),
  .msg_type_o   (msg_type_o)
);

// ==== verification/fix_session_tb.sv ====
//==========================================================================
// Testbench for the FIX session-control top level.
// Six directed tests; a reference model of the window and the heartbeat
// timer predicts each accepted message, and a compare process checks it.
//==========================================================================

module fix_session_tb;

  import fix_session_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_TIMEOUT = 64;
  // 71 ticks, 7 time changes (one with a tick) and 5 configs, each bounded by the idle wait
  localparam int STEPS        = 83;
  localparam int WATCHDOG_TIME =
    (RESET_CYCLES + STEPS * (IDLE_TIMEOUT + 3) + 200) * CLK_PERIOD;

  logic          clk = 1'b0;
  logic          reset_i = 1'b1;
  logic          configure_i = 1'b0;
  connect_type_t connect_type_i = CONNECT_INITIATOR;
  time_of_day_t  start_time_i = '0;
  time_of_day_t  end_time_i = '0;
  interval_t     heartbeat_int_i = '0;
  time_of_day_t  time_i = '0;
  logic          tick_i = 1'b0;
  logic          msg_ready_i = 1'b1;
  logic          msg_valid_o;
  msg_type_t     msg_type_o;

  // Reference model state
  session_state_t ref_state;
  logic           ref_cfg_valid;
  connect_type_t  ref_conn;
  time_of_day_t   ref_start;
  time_of_day_t   ref_end;
  interval_t      ref_int;
  interval_t      ref_quiet;
  logic           ref_hb_pend;

  int cnt_logon = 0;
  int cnt_hb = 0;
  int cnt_logout = 0;
  int cmp_errors = 0;
  int stim_errors = 0;
  int tests_run = 0;
  int base_logon;
  int base_hb;
  int base_logout;
  int base_errors;

  logic        bp_mode = 1'b0;
  integer      seed = 32'h7f437770;
  logic [31:0] rnd;

  fix_session_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Ready is random under back-pressure, high otherwise
  always @(posedge clk) begin
    #1;
    if (bp_mode) begin
      rnd = $random(seed);
      msg_ready_i = rnd[0];
    end else begin
      msg_ready_i = 1'b1;
    end
  end

  //==========================================================================
  // Reference model
  //==========================================================================

  // Next message by priority: logout, logon, heartbeat
  function automatic msg_type_t predict_next();
    return (ref_state == S_LOGOUT_PEND) ? MSG_LOGOUT :
           (ref_state == S_LOGON_PEND)  ? MSG_LOGON  : MSG_HEARTBEAT;
  endfunction

  function automatic logic pending_message();
    return (ref_state == S_LOGON_PEND) || (ref_state == S_LOGOUT_PEND) || ref_hb_pend;
  endfunction

  always @(posedge clk) begin
    if (reset_i) begin
      ref_state     = S_IDLE;
      ref_cfg_valid = 1'b0;
      ref_quiet     = '0;
      ref_hb_pend   = 1'b0;
    end else begin
      // Accepted message is handled first since any send restarts the quiet time
      if (msg_valid_o && msg_ready_i) begin
        assert (pending_message()) else begin
          cmp_errors++;
          $display("unexpected message 0x%h sent with nothing pending", msg_type_o);
        end
        assert (msg_type_o == predict_next()) else begin
          cmp_errors++;
          $display("error: msg_type_o expected 0x%h got 0x%h", predict_next(), msg_type_o);
        end
        case (msg_type_o)
          MSG_LOGON:  cnt_logon++;
          MSG_LOGOUT: cnt_logout++;
          default:    cnt_hb++;
        endcase
        if (msg_type_o == MSG_LOGON && ref_state == S_LOGON_PEND) begin
          ref_state = S_ACTIVE;
        end else if (msg_type_o == MSG_LOGOUT && ref_state == S_LOGOUT_PEND) begin
          ref_state = S_IDLE;
        end
        ref_quiet   = '0;
        ref_hb_pend = 1'b0;
      end
      if (configure_i) begin
        ref_cfg_valid = 1'b1;
        ref_conn      = connect_type_i;
        ref_start     = start_time_i;
        ref_end       = end_time_i;
        ref_int       = heartbeat_int_i;
      end
      // Ticks count only while active and no heartbeat waits
      if (tick_i && ref_state == S_ACTIVE && !ref_hb_pend) begin
        ref_quiet = ref_quiet + 1'b1;
      end
      if (ref_state == S_ACTIVE && ref_int != '0 && ref_quiet >= ref_int) begin
        ref_hb_pend = 1'b1;
      end
      case (ref_state)
        S_IDLE: begin
          if (ref_cfg_valid && ref_start <= time_i && time_i < ref_end) begin
            ref_state = (ref_conn == CONNECT_INITIATOR) ? S_LOGON_PEND : S_ACTIVE;
            ref_quiet = '0;
          end
        end
        S_ACTIVE: begin
          if (time_i >= ref_end) begin
            ref_state   = (ref_conn == CONNECT_INITIATOR) ? S_LOGOUT_PEND : S_IDLE;
            ref_quiet   = '0;
            ref_hb_pend = 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
  end

  //==========================================================================
  // Stimulus tasks
  //==========================================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Wait until the model expects nothing and the output slot is empty
  task automatic wait_idle();
    int waited;
    waited = 0;
    while ((pending_message() || msg_valid_o) && waited < IDLE_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    assert (waited < IDLE_TIMEOUT) else begin
      stim_errors++;
      $display("timeout: message still pending after %0d cycles", IDLE_TIMEOUT);
    end
  endtask

  task automatic load_config(connect_type_t ct, time_of_day_t st, time_of_day_t et,
                             interval_t hb);
    next_cycle();
    configure_i     = 1'b1;
    connect_type_i  = ct;
    start_time_i    = st;
    end_time_i      = et;
    heartbeat_int_i = hb;
    next_cycle();
    configure_i = 1'b0;
    wait_idle();
  endtask

  task automatic set_time(time_of_day_t t);
    next_cycle();
    time_i = t;
    next_cycle();
    wait_idle();
  endtask

  // Time moves one cycle after the tick, while the heartbeat request is fresh
  task automatic tick_then_set_time(time_of_day_t t);
    next_cycle();
    tick_i = 1'b1;
    next_cycle();
    tick_i = 1'b0;
    time_i = t;
    next_cycle();
    wait_idle();
  endtask

  task automatic send_ticks(int n);
    repeat (n) begin
      next_cycle();
      tick_i = 1'b1;
      next_cycle();
      tick_i = 1'b0;
      wait_idle();
    end
  endtask

  task automatic start_test();
    base_logon  = cnt_logon;
    base_hb     = cnt_hb;
    base_logout = cnt_logout;
    base_errors = cmp_errors + stim_errors;
  endtask

  task automatic end_test(string name, int exp_logon, int exp_hb, int exp_logout);
    assert (cnt_logon - base_logon == exp_logon) else begin
      stim_errors++;
      $display("%s: expected %0d logons, saw %0d", name, exp_logon, cnt_logon - base_logon);
    end
    assert (cnt_hb - base_hb == exp_hb) else begin
      stim_errors++;
      $display("%s: expected %0d heartbeats, saw %0d", name, exp_hb, cnt_hb - base_hb);
    end
    assert (cnt_logout - base_logout == exp_logout) else begin
      stim_errors++;
      $display("%s: expected %0d logouts, saw %0d", name, exp_logout,
               cnt_logout - base_logout);
    end
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name,
             cmp_errors + stim_errors - base_errors);
  endtask

  //==========================================================================
  // Test sequence
  //==========================================================================

  initial begin
    repeat (RESET_CYCLES) next_cycle();
    reset_i = 1'b0;

    start_test();
    set_time(16'd100);
    send_ticks(10);
    set_time(16'd600);
    send_ticks(10);
    end_test("idle before configure", 0, 0, 0);

    start_test();
    set_time(16'd480);
    load_config(CONNECT_INITIATOR, 16'd540, 16'd1020, 8'd4);
    send_ticks(3);
    set_time(16'd540);
    end_test("initiator logon", 1, 0, 0);

    // One heartbeat per interval of ticks, then a shorter interval
    start_test();
    send_ticks(12);
    load_config(CONNECT_INITIATOR, 16'd540, 16'd1020, 8'd2);
    send_ticks(6);
    end_test("heartbeat spacing", 0, 12 / 4 + 6 / 2, 0);

    start_test();
    bp_mode = 1'b1;
    load_config(CONNECT_INITIATOR, 16'd540, 16'd1020, 8'd3);
    send_ticks(15);
    bp_mode = 1'b0;
    end_test("random back-pressure", 0, 15 / 3, 0);

    // Heartbeat falls due as the window closes and the logout wins
    start_test();
    load_config(CONNECT_INITIATOR, 16'd540, 16'd1020, 8'd2);
    send_ticks(1);
    tick_then_set_time(16'd1020);
    send_ticks(6);
    end_test("logout at end time", 0, 0, 1);

    start_test();
    load_config(connect_type_t'(1), 16'd1080, 16'd1200, 8'd2);
    set_time(16'd1080);
    send_ticks(4);
    set_time(16'd1200);
    send_ticks(4);
    end_test("acceptor session", 0, 4 / 2, 0);

    $display("%0d tests run, %0d errors", tests_run, cmp_errors + stim_errors);
    if (cmp_errors + stim_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog: tests did not complete within %0d time units", WATCHDOG_TIME);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog/fix_session_pkg.sv ====
//==========================================================================
// Shared types for the FIX session-control block.
// Import wildcard inside module bodies and use scoped names in port lists.
//==========================================================================

package fix_session_pkg;

  // Field widths
  localparam int TIME_W     = 16;
  localparam int INTERVAL_W = 8;
  localparam int CONNECT_W  = 2;

  // Minutes since midnight
  typedef logic [TIME_W-1:0] time_of_day_t;

  // Seconds, used for the heartbeat interval
  typedef logic [INTERVAL_W-1:0] interval_t;

  // 0 is initiator, anything else behaves as acceptor
  typedef logic [CONNECT_W-1:0] connect_type_t;

  localparam connect_type_t CONNECT_INITIATOR = connect_type_t'(0);

  // Message codes handed to the downstream message builder
  typedef enum logic [1:0] {
    MSG_HEARTBEAT = 2'd0,
    MSG_LOGON     = 2'd1,
    MSG_LOGOUT    = 2'd2
  } msg_type_t;

  // Session window FSM states
  typedef enum logic [1:0] {
    S_IDLE        = 2'd0,
    S_LOGON_PEND  = 2'd1,
    S_ACTIVE      = 2'd2,
    S_LOGOUT_PEND = 2'd3
  } session_state_t;

endpackage

// ==== verilog/fix_session_top.sv ====
//==========================================================================
// FIX session-control top level.
// Configuration register feeding the session window and heartbeat timer,
// whose requests are merged by the message arbiter into one stream.
//==========================================================================

module fix_session_top (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          configure_i,
  input  fix_session_pkg::connect_type_t connect_type_i,
  input  fix_session_pkg::time_of_day_t  start_time_i,
  input  fix_session_pkg::time_of_day_t  end_time_i,
  input  fix_session_pkg::interval_t     heartbeat_int_i,
  input  fix_session_pkg::time_of_day_t  time_i,
  input  logic                          tick_i,
  input  logic                          msg_ready_i,
  output logic                          msg_valid_o,
  output fix_session_pkg::msg_type_t     msg_type_o
);

  import fix_session_pkg::*;

  // Registered settings
  logic          cfg_valid;
  connect_type_t cfg_connect_type;
  time_of_day_t  cfg_start_time;
  time_of_day_t  cfg_end_time;
  interval_t     cfg_heartbeat_int;

  // Requests and send feedback
  logic          logon_req;
  logic          logout_req;
  logic          session_active;
  logic          hb_req;
  logic          msg_sent;
  msg_type_t     sent_type;

  session_config u_config (
    .clk                 (clk),
    .reset_i             (reset_i),
    .configure_i         (configure_i),
    .connect_type_i      (connect_type_i),
    .start_time_i        (start_time_i),
    .end_time_i          (end_time_i),
    .heartbeat_int_i     (heartbeat_int_i),
    .cfg_valid_o         (cfg_valid),
    .cfg_connect_type_o  (cfg_connect_type),
    .cfg_start_time_o    (cfg_start_time),
    .cfg_end_time_o      (cfg_end_time),
    .cfg_heartbeat_int_o (cfg_heartbeat_int)
  );

  session_window u_window (
    .clk                (clk),
    .reset_i            (reset_i),
    .cfg_valid_i        (cfg_valid),
    .cfg_connect_type_i (cfg_connect_type),
    .cfg_start_time_i   (cfg_start_time),
    .cfg_end_time_i     (cfg_end_time),
    .time_i             (time_i),
    .msg_sent_i         (msg_sent),
    .sent_type_i        (sent_type),
    .logon_req_o        (logon_req),
    .logout_req_o       (logout_req),
    .session_active_o   (session_active)
  );

  heartbeat_timer u_hb_timer (
    .clk                 (clk),
    .reset_i             (reset_i),
    .session_active_i    (session_active),
    .tick_i              (tick_i),
    .msg_sent_i          (msg_sent),
    .cfg_heartbeat_int_i (cfg_heartbeat_int),
    .hb_req_o            (hb_req)
  );

  session_msg_arbiter u_arbiter (
    .clk          (clk),
    .reset_i      (reset_i),
    .logon_req_i  (logon_req),
    .logout_req_i (logout_req),
    .hb_req_i     (hb_req),
    .msg_ready_i  (msg_ready_i),
    .msg_valid_o  (msg_valid_o),
    .msg_type_o   (msg_type_o),
    .msg_sent_o   (msg_sent),
    .sent_type_o  (sent_type)
  );

endmodule

// ==== verilog/heartbeat_timer.sv ====
//==========================================================================
// Heartbeat timer.
// Counts one-second ticks of link silence while the session is active and
// requests a heartbeat once the configured interval has elapsed.
//==========================================================================

module heartbeat_timer (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      session_active_i,
  input  logic                      tick_i,
  input  logic                      msg_sent_i,
  input  fix_session_pkg::interval_t cfg_heartbeat_int_i,
  output logic                      hb_req_o
);

  import fix_session_pkg::*;

  interval_t quiet_cnt_q;
  logic      interval_done;

  // A zero interval disables heartbeats
  assign interval_done = (cfg_heartbeat_int_i != '0) &&
                         (quiet_cnt_q >= cfg_heartbeat_int_i);

  //========================================================================
  // Quiet-time counter
  //========================================================================

  // Saturates at the interval, so a pending request never wraps the count
  always_ff @(posedge clk) begin
    if (reset_i) begin
      quiet_cnt_q <= '0;
    end else if (!session_active_i || msg_sent_i) begin
      quiet_cnt_q <= '0;
    end else if (tick_i && (quiet_cnt_q < cfg_heartbeat_int_i)) begin
      quiet_cnt_q <= quiet_cnt_q + 1'b1;
    end
  end

  //========================================================================
  // Request flag
  //========================================================================

  // Any sent message counts as traffic and clears the request.
  // Leaving the active state drops it too, so nothing trails a logout
  always_ff @(posedge clk) begin
    if (reset_i) begin
      hb_req_o <= 1'b0;
    end else if (!session_active_i || msg_sent_i) begin
      hb_req_o <= 1'b0;
    end else if (interval_done) begin
      hb_req_o <= 1'b1;
    end
  end

endmodule

// ==== verilog/session_config.sv ====
//==========================================================================
// Session configuration register.
// Captures the session parameters on a configure pulse and holds them
// until the next pulse. cfg_valid_o marks that a set has been loaded.
//==========================================================================

module session_config (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          configure_i,
  input  fix_session_pkg::connect_type_t connect_type_i,
  input  fix_session_pkg::time_of_day_t  start_time_i,
  input  fix_session_pkg::time_of_day_t  end_time_i,
  input  fix_session_pkg::interval_t     heartbeat_int_i,
  output logic                          cfg_valid_o,
  output fix_session_pkg::connect_type_t cfg_connect_type_o,
  output fix_session_pkg::time_of_day_t  cfg_start_time_o,
  output fix_session_pkg::time_of_day_t  cfg_end_time_o,
  output fix_session_pkg::interval_t     cfg_heartbeat_int_o
);

  //========================================================================
  // Valid flag
  //========================================================================

  // Set by the first configure pulse, stays set until reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfg_valid_o <= 1'b0;
    end else if (configure_i) begin
      cfg_valid_o <= 1'b1;
    end
  end

  //========================================================================
  // Parameter registers
  //========================================================================

  // Values hold between pulses; a new pulse overwrites the whole set
  always_ff @(posedge clk) begin
    if (configure_i) begin
      cfg_connect_type_o  <= connect_type_i;
      cfg_start_time_o    <= start_time_i;
      cfg_end_time_o      <= end_time_i;
      cfg_heartbeat_int_o <= heartbeat_int_i;
    end
  end

endmodule

// ==== verilog/session_msg_arbiter.sv ====
//==========================================================================
// Session message arbiter.
// Merges logon, logout and heartbeat requests into one valid/ready stream
// of message codes. Fixed priority: logout, logon, heartbeat. The chosen
// message is held until the message builder accepts it.
//==========================================================================

module session_msg_arbiter (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       logon_req_i,
  input  logic                       logout_req_i,
  input  logic                       hb_req_i,
  input  logic                       msg_ready_i,
  output logic                       msg_valid_o,
  output fix_session_pkg::msg_type_t msg_type_o,
  output logic                       msg_sent_o,
  output fix_session_pkg::msg_type_t sent_type_o
);

  import fix_session_pkg::*;

  logic      out_free;
  logic      take_logout;
  logic      take_logon;
  logic      take_hb;
  logic      take_any;
  msg_type_t next_type;

  assign msg_sent_o  = msg_valid_o && msg_ready_i;
  assign sent_type_o = msg_type_o;

  // Output slot can load when empty or when its message leaves this cycle
  assign out_free = !msg_valid_o || msg_ready_i;

  //========================================================================
  // Request masking and priority
  //========================================================================

  // A request whose message is leaving now is still high for this cycle,
  // so it must not be taken a second time. Heartbeat requests clear on
  // any send, so they are masked on every send
  assign take_logout = logout_req_i && !(msg_sent_o && (msg_type_o == MSG_LOGOUT));
  assign take_logon  = logon_req_i  && !(msg_sent_o && (msg_type_o == MSG_LOGON));
  assign take_hb     = hb_req_i     && !msg_sent_o;
  assign take_any    = take_logout || take_logon || take_hb;

  always_comb begin
    if (take_logout) begin
      next_type = MSG_LOGOUT;
    end else if (take_logon) begin
      next_type = MSG_LOGON;
    end else begin
      next_type = MSG_HEARTBEAT;
    end
  end

  //========================================================================
  // Output register
  //========================================================================

  always_ff @(posedge clk) begin
    if (reset_i) begin
      msg_valid_o <= 1'b0;
    end else if (out_free) begin
      msg_valid_o <= take_any;
    end
  end

  // Type only moves when the slot is free, so it is stable under back-pressure
  always_ff @(posedge clk) begin
    if (out_free && take_any) begin
      msg_type_o <= next_type;
    end
  end

endmodule

// ==== verilog/session_window.sv ====
//==========================================================================
// Session window FSM.
// Follows the time of day against the configured start and end times and
// raises logon and logout requests. Advances when the arbiter reports that
// the matching message has been sent.
//==========================================================================

module session_window (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          cfg_valid_i,
  input  fix_session_pkg::connect_type_t cfg_connect_type_i,
  input  fix_session_pkg::time_of_day_t  cfg_start_time_i,
  input  fix_session_pkg::time_of_day_t  cfg_end_time_i,
  input  fix_session_pkg::time_of_day_t  time_i,
  input  logic                          msg_sent_i,
  input  fix_session_pkg::msg_type_t     sent_type_i,
  output logic                          logon_req_o,
  output logic                          logout_req_o,
  output logic                          session_active_o
);

  import fix_session_pkg::*;

  session_state_t state_q;
  session_state_t state_d;
  logic           in_window;
  logic           is_initiator;
  logic           logon_sent;
  logic           logout_sent;

  // Window is half open, start inclusive and end exclusive
  assign in_window    = (cfg_start_time_i <= time_i) && (time_i < cfg_end_time_i);
  assign is_initiator = (cfg_connect_type_i == CONNECT_INITIATOR);
  assign logon_sent   = msg_sent_i && (sent_type_i == MSG_LOGON);
  assign logout_sent  = msg_sent_i && (sent_type_i == MSG_LOGOUT);

  //========================================================================
  // Next state
  //========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cfg_valid_i && in_window) begin
          // Acceptor waits for the peer, so it goes active at once
          state_d = is_initiator ? S_LOGON_PEND : S_ACTIVE;
        end
      end
      S_LOGON_PEND: begin
        if (logon_sent) begin
          state_d = S_ACTIVE;
        end
      end
      S_ACTIVE: begin
        if (time_i >= cfg_end_time_i) begin
          state_d = is_initiator ? S_LOGOUT_PEND : S_IDLE;
        end
      end
      S_LOGOUT_PEND: begin
        if (logout_sent) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Requests are state decodes, so they hold until the message goes out
  assign logon_req_o      = (state_q == S_LOGON_PEND);
  assign logout_req_o     = (state_q == S_LOGOUT_PEND);
  assign session_active_o = (state_q == S_ACTIVE);

endmodule
